/* files.f */
+incdir+logic
logic/ofdm_sample_pkg.sv
logic/ofdm_carrier_pkg.sv
logic/sample_ram.sv
logic/serial_divider.sv
logic/channel_estimator.sv
logic/symbol_sequencer.sv
logic/carrier_normalizer.sv
logic/equalizer_top.sv
testbench/equalizer_properties.sv
testbench/equalizer_checker.sv
testbench/equalizer_tb.sv

/* logic/carrier_normalizer.sv */
`include "eq_cfg.svh"

module carrier_normalizer
    import ofdm_sample_pkg::*;
(
    input  logic    clock,
    input  logic    reset,
    input  sample_t sample_i,
    input  sample_t est_i,
    input  logic    stb_i,
    output sample_t sample_o,
    output logic    sample_stb_o,
    output logic    done_o
);

    logic                       vld_in;
    logic                       vld_mul;
    logic                       vld_sum;
    sample_t                    x_q;
    sample_t                    h_q;
    prod_t                      xr_hr;
    prod_t                      xi_hi;
    prod_t                      xi_hr;
    prod_t                      xr_hi;
    prod_t                      hr_hr;
    prod_t                      hi_hi;
    prod_t                      num_re;
    prod_t                      num_im;
    logic [2*`IQ_W-1:0]         mag_sq;
    logic [`DIV_DIVIDEND_W-1:0] quo_re;
    logic [`DIV_DIVIDEND_W-1:0] quo_im;
    logic                       done_re;
    logic                       done_im;

    always_ff @(posedge clock) begin
        if (reset) begin
            vld_in <= 1'b0;
            vld_mul <= 1'b0;
            vld_sum <= 1'b0;
        end else begin
            vld_in <= stb_i;
            vld_mul <= vld_in;
            vld_sum <= vld_mul;
        end
    end

    always_ff @(posedge clock) begin
        x_q <= sample_i;
        h_q <= est_i;

        xr_hr <= x_q.iq.re * h_q.iq.re;
        xi_hi <= x_q.iq.im * h_q.iq.im;
        xi_hr <= x_q.iq.im * h_q.iq.re;
        xr_hi <= x_q.iq.re * h_q.iq.im;
        hr_hr <= h_q.iq.re * h_q.iq.re;
        hi_hi <= h_q.iq.im * h_q.iq.im;

        // x times conj(h), scaled up before the division
        num_re <= (xr_hr + xi_hi) <<< `EQ_SCALE_SHIFT;
        num_im <= (xi_hr - xr_hi) <<< `EQ_SCALE_SHIFT;
        mag_sq <= hr_hr + hi_hi;
    end

    serial_divider u_div_re (
        .clock      (clock),
        .reset      (reset),
        .dividend_i (num_re),
        .divisor_i  (mag_sq[`DIV_DIVISOR_W-1:0]),
        .start_i    (vld_sum),
        .quotient_o (quo_re),
        .done_o     (done_re)
    );

    serial_divider u_div_im (
        .clock      (clock),
        .reset      (reset),
        .dividend_i (num_im),
        .divisor_i  (mag_sq[`DIV_DIVISOR_W-1:0]),
        .start_i    (vld_sum),
        .quotient_o (quo_im),
        .done_o     (done_im)
    );

    // keep the quotient sign above its low 15 bits
    assign sample_o.raw = {quo_re[`DIV_DIVIDEND_W-1], quo_re[`IQ_W-2:0],
                           quo_im[`DIV_DIVIDEND_W-1], quo_im[`IQ_W-2:0]};
    assign sample_stb_o = done_re && done_im;
    assign done_o = done_re && done_im;

endmodule

/* logic/channel_estimator.sv */
`include "eq_cfg.svh"

module channel_estimator
    import ofdm_sample_pkg::*;
    import ofdm_carrier_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  sample_t      sample_i,
    input  logic         sample_stb_i,
    input  carrier_idx_t est_raddr_i,
    output sample_t      est_data_o,
    output logic         est_ready_o
);

    // bit 6 marks the second LTS, bit 7 ends the capture
    logic [`FFT_ADDR_W+1:0]  lts_cnt;
    logic                    capture;
    logic                    wr_stb;
    logic                    wr_second;
    carrier_idx_t            wr_idx;
    sample_t                 wr_sample;
    logic signed [`IQ_W:0]   sum_re;
    logic signed [`IQ_W:0]   sum_im;
    logic signed [`IQ_W-1:0] mean_re;
    logic signed [`IQ_W-1:0] mean_im;
    logic [2*`IQ_W-1:0]      ram_wdata;
    logic [2*`IQ_W-1:0]      ram_rdata;

    assign capture = sample_stb_i && !lts_cnt[`FFT_ADDR_W+1];

    always_ff @(posedge clock) begin
        if (reset) begin
            lts_cnt <= '0;
            wr_stb <= 1'b0;
            est_ready_o <= 1'b0;
        end else begin
            wr_stb <= capture;
            if (capture) begin
                lts_cnt <= lts_cnt + 1'b1;
            end
            if (wr_stb && wr_second && wr_idx == carrier_idx_t'(`FFT_LEN-1)) begin
                est_ready_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        wr_sample <= sample_i;
        wr_idx <= lts_cnt[`FFT_ADDR_W-1:0];
        wr_second <= lts_cnt[`FFT_ADDR_W];
    end

    // the first LTS word of this carrier is on the read port during the write stage
    assign sum_re = est_data_o.iq.re + wr_sample.iq.re;
    assign sum_im = est_data_o.iq.im + wr_sample.iq.im;
    assign mean_re = LTS_REF[wr_idx] ? -sum_re[`IQ_W:1] : sum_re[`IQ_W:1];
    assign mean_im = LTS_REF[wr_idx] ? -sum_im[`IQ_W:1] : sum_im[`IQ_W:1];

    assign ram_wdata = wr_second ? {mean_re, mean_im} : wr_sample.raw;
    assign est_data_o.raw = ram_rdata;

    sample_ram u_est_ram (
        .clock   (clock),
        .we_i    (wr_stb),
        .waddr_i (wr_idx),
        .wdata_i (ram_wdata),
        .raddr_i (est_raddr_i),
        .rdata_o (ram_rdata)
    );

endmodule

/* logic/eq_cfg.svh */
`ifndef EQ_CFG_SVH
`define EQ_CFG_SVH

// carrier plan
`define FFT_LEN 64
`define FFT_ADDR_W 6
`define NUM_DATA_CARRIERS 48
`define NUM_PILOTS 4

// sample component width, a sample word holds re and im
`define IQ_W 16

// normalization
`define EQ_SCALE_SHIFT 11
`define DIV_DIVIDEND_W 32
`define DIV_DIVISOR_W 24

`endif

/* logic/equalizer_top.sv */
module equalizer_top
    import ofdm_sample_pkg::*;
    import ofdm_carrier_pkg::*;
(
    input  logic    clock,
    input  logic    reset,
    input  sample_t sample_i,
    input  logic    sample_stb_i,
    output sample_t sample_o,
    output logic    sample_stb_o,
    output prod_t   pilot_sum_re_o,
    output prod_t   pilot_sum_im_o,
    output logic    pilot_sum_stb_o
);

    carrier_idx_t est_raddr;
    sample_t      est_data;
    logic         est_ready;
    sample_t      norm_sample;
    sample_t      norm_est;
    logic         norm_stb;
    logic         norm_done;

    channel_estimator u_estimator (
        .clock        (clock),
        .reset        (reset),
        .sample_i     (sample_i),
        .sample_stb_i (sample_stb_i),
        .est_raddr_i  (est_raddr),
        .est_data_o   (est_data),
        .est_ready_o  (est_ready)
    );

    symbol_sequencer u_sequencer (
        .clock           (clock),
        .reset           (reset),
        .sample_i        (sample_i),
        .sample_stb_i    (sample_stb_i),
        .est_ready_i     (est_ready),
        .est_data_i      (est_data),
        .norm_done_i     (norm_done),
        .est_raddr_o     (est_raddr),
        .norm_sample_o   (norm_sample),
        .norm_est_o      (norm_est),
        .norm_stb_o      (norm_stb),
        .pilot_sum_re_o  (pilot_sum_re_o),
        .pilot_sum_im_o  (pilot_sum_im_o),
        .pilot_sum_stb_o (pilot_sum_stb_o)
    );

    carrier_normalizer u_normalizer (
        .clock        (clock),
        .reset        (reset),
        .sample_i     (norm_sample),
        .est_i        (norm_est),
        .stb_i        (norm_stb),
        .sample_o     (sample_o),
        .sample_stb_o (sample_stb_o),
        .done_o       (norm_done)
    );

endmodule

/* logic/ofdm_carrier_pkg.sv */
`include "eq_cfg.svh"

package ofdm_carrier_pkg;

    typedef logic [`FFT_ADDR_W-1:0] carrier_idx_t;

    // bit 0 is DC, bits 1..26 positive carriers, bits 38..63 negative carriers
    localparam logic [`FFT_LEN-1:0] LEGACY_MASK =
        64'b1111111111111111111111111100000000000111111111111111111111111110;

    // carriers 7, 21, 43 and 57
    localparam logic [`FFT_LEN-1:0] PILOT_MASK =
        64'b0000001000000000000010000000000000000000001000000000000010000000;

    localparam logic [`FFT_LEN-1:0] DATA_MASK = LEGACY_MASK & ~PILOT_MASK;

    // a one marks a carrier whose reference value is -1
    localparam logic [`FFT_LEN-1:0] LTS_REF =
        64'b0000101001100000010100110000000000000000010101100111110101001100;

    localparam int POLARITY_LEN = 127;

    // one bit per data symbol, bit 0 first
    localparam logic [POLARITY_LEN-1:0] POLARITY_SEQ =
        127'b1111111000111011000101001011111010101000010110111100111001010110011000001101101011101000110010001000000100100110100111101110000;

endpackage

/* logic/ofdm_sample_pkg.sv */
`include "eq_cfg.svh"

package ofdm_sample_pkg;

    typedef struct packed {
        logic signed [`IQ_W-1:0] re;
        logic signed [`IQ_W-1:0] im;
    } iq_t;

    // raw view for storage and ports, iq view for arithmetic
    typedef union packed {
        logic [2*`IQ_W-1:0] raw;
        iq_t                iq;
    } sample_t;

    typedef logic signed [2*`IQ_W-1:0] prod_t;

endpackage

/* logic/sample_ram.sv */
`include "eq_cfg.svh"

module sample_ram (
    input  logic                   clock,
    input  logic                   we_i,
    input  logic [`FFT_ADDR_W-1:0] waddr_i,
    input  logic [2*`IQ_W-1:0]     wdata_i,
    input  logic [`FFT_ADDR_W-1:0] raddr_i,
    output logic [2*`IQ_W-1:0]     rdata_o
);

    logic [2*`IQ_W-1:0] mem [`FFT_LEN];

    always_ff @(posedge clock) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
        rdata_o <= mem[raddr_i];
    end

endmodule

/* logic/serial_divider.sv */
`include "eq_cfg.svh"

module serial_divider (
    input  logic                       clock,
    input  logic                       reset,
    input  logic [`DIV_DIVIDEND_W-1:0] dividend_i,
    input  logic [`DIV_DIVISOR_W-1:0]  divisor_i,
    input  logic                       start_i,
    output logic [`DIV_DIVIDEND_W-1:0] quotient_o,
    output logic                       done_o
);

    typedef enum logic [1:0] {DIV_IDLE, DIV_RUN, DIV_SIGN} div_state_t;

    div_state_t                          state;
    logic [$clog2(`DIV_DIVIDEND_W)-1:0]  bit_cnt;
    logic                                neg;
    logic [`DIV_DIVIDEND_W-1:0]          quo;
    logic [`DIV_DIVISOR_W-1:0]           rem;
    logic [`DIV_DIVISOR_W-1:0]           den;
    logic [`DIV_DIVISOR_W+1:0]           trial;

    // next dividend bit shifted into the remainder, then a trial subtract
    assign trial = {1'b0, rem, quo[`DIV_DIVIDEND_W-1]} - {2'b00, den};

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= DIV_IDLE;
            bit_cnt <= '0;
            done_o <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (start_i) begin
                state <= DIV_RUN;
                bit_cnt <= '0;
            end else begin
                case (state)
                    DIV_RUN: begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == `DIV_DIVIDEND_W - 1) begin
                            state <= DIV_SIGN;
                        end
                    end
                    DIV_SIGN: begin
                        done_o <= 1'b1;
                        state <= DIV_IDLE;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clock) begin
        if (start_i) begin
            neg <= dividend_i[`DIV_DIVIDEND_W-1];
            quo <= dividend_i[`DIV_DIVIDEND_W-1] ? -dividend_i : dividend_i;
            rem <= '0;
            den <= divisor_i;
        end else if (state == DIV_RUN) begin
            if (!trial[`DIV_DIVISOR_W+1]) begin
                rem <= trial[`DIV_DIVISOR_W-1:0];
                quo <= {quo[`DIV_DIVIDEND_W-2:0], 1'b1};
            end else begin
                rem <= {rem[`DIV_DIVISOR_W-2:0], quo[`DIV_DIVIDEND_W-1]};
                quo <= {quo[`DIV_DIVIDEND_W-2:0], 1'b0};
            end
        end else if (state == DIV_SIGN) begin
            // magnitude quotient takes the dividend sign, so it truncates toward zero
            quotient_o <= neg ? -quo : quo;
        end
    end

endmodule

/* logic/symbol_sequencer.sv */
`include "eq_cfg.svh"

module symbol_sequencer
    import ofdm_sample_pkg::*;
    import ofdm_carrier_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  sample_t      sample_i,
    input  logic         sample_stb_i,
    input  logic         est_ready_i,
    input  sample_t      est_data_i,
    input  logic         norm_done_i,
    output carrier_idx_t est_raddr_o,
    output sample_t      norm_sample_o,
    output sample_t      norm_est_o,
    output logic         norm_stb_o,
    output prod_t        pilot_sum_re_o,
    output prod_t        pilot_sum_im_o,
    output logic         pilot_sum_stb_o
);

    // the pilot at carrier 21 takes the inverted polarity
    localparam carrier_idx_t FLIP_PILOT = carrier_idx_t'(21);

    typedef enum logic [1:0] {RD_IDLE, RD_SEEK, RD_ISSUE, RD_WAIT} rd_state_t;

    rd_state_t                             rd_state;
    carrier_idx_t                          in_cnt;
    carrier_idx_t                          st_idx;
    sample_t                               st_sample;
    logic                                  st_stb;
    logic                                  st_data;
    logic [$clog2(POLARITY_LEN)-1:0]       pol_ptr;
    logic                                  pol_bit;
    logic                                  pilot_neg;
    logic signed [`IQ_W-1:0]               conj_re;
    logic signed [`IQ_W-1:0]               conj_im;
    prod_t                                 prod_re;
    prod_t                                 prod_im;
    logic                                  prod_vld;
    logic [$clog2(`NUM_PILOTS)-1:0]        pilot_cnt;
    carrier_idx_t                          rd_idx;
    logic [$clog2(`NUM_DATA_CARRIERS)-1:0] out_cnt;
    logic [2*`IQ_W-1:0]                    buf_rdata;

    assign st_data = st_stb && est_ready_i;

    always_ff @(posedge clock) begin
        if (reset) begin
            in_cnt <= '0;
            st_stb <= 1'b0;
            pol_ptr <= '0;
            prod_vld <= 1'b0;
            pilot_cnt <= '0;
            pilot_sum_stb_o <= 1'b0;
            rd_state <= RD_IDLE;
        end else begin
            st_stb <= sample_stb_i;
            if (sample_stb_i) begin
                in_cnt <= in_cnt + 1'b1;
            end
            if (st_data && st_idx == '0) begin
                pol_ptr <= (pol_ptr == POLARITY_LEN - 1) ? '0 : pol_ptr + 1'b1;
            end
            prod_vld <= st_data && PILOT_MASK[st_idx];
            if (prod_vld) begin
                pilot_cnt <= pilot_cnt + 1'b1;
            end
            pilot_sum_stb_o <= prod_vld && pilot_cnt == `NUM_PILOTS - 1;

            case (rd_state)
                RD_IDLE: begin
                    if (st_data && st_idx == carrier_idx_t'(`FFT_LEN-1)) begin
                        rd_state <= RD_SEEK;
                    end
                end
                RD_SEEK: begin
                    if (DATA_MASK[rd_idx]) begin
                        rd_state <= RD_ISSUE;
                    end
                end
                RD_ISSUE: begin
                    rd_state <= RD_WAIT;
                end
                default: begin
                    if (norm_done_i) begin
                        rd_state <= (out_cnt == `NUM_DATA_CARRIERS - 1) ? RD_IDLE : RD_SEEK;
                    end
                end
            endcase
        end
    end

    // conjugate of the pilot, sign flipped by its polarity
    assign pilot_neg = pol_bit ^ (st_idx == FLIP_PILOT);
    assign conj_re = pilot_neg ? -st_sample.iq.re : st_sample.iq.re;
    assign conj_im = pilot_neg ? st_sample.iq.im : -st_sample.iq.im;

    always_ff @(posedge clock) begin
        st_sample <= sample_i;
        st_idx <= in_cnt;
        if (st_data && st_idx == '0) begin
            pol_bit <= POLARITY_SEQ[pol_ptr];
        end
        prod_re <= conj_re * est_data_i.iq.re - conj_im * est_data_i.iq.im;
        prod_im <= conj_re * est_data_i.iq.im + conj_im * est_data_i.iq.re;
        if (prod_vld) begin
            pilot_sum_re_o <= (pilot_cnt == '0) ? prod_re : pilot_sum_re_o + prod_re;
            pilot_sum_im_o <= (pilot_cnt == '0) ? prod_im : pilot_sum_im_o + prod_im;
        end

        if (rd_state == RD_IDLE) begin
            rd_idx <= '0;
            out_cnt <= '0;
        end else if (rd_state == RD_SEEK && !DATA_MASK[rd_idx]) begin
            rd_idx <= rd_idx + 1'b1;
        end else if (rd_state == RD_WAIT && norm_done_i) begin
            rd_idx <= rd_idx + 1'b1;
            out_cnt <= out_cnt + 1'b1;
        end
    end

    // address leads the stage by one cycle to cover the RAM read latency
    assign est_raddr_o = (rd_state == RD_IDLE) ? in_cnt : rd_idx;

    assign norm_stb_o = (rd_state == RD_ISSUE);
    assign norm_sample_o.raw = buf_rdata;
    assign norm_est_o = est_data_i;

    sample_ram u_sym_buf (
        .clock   (clock),
        .we_i    (st_data),
        .waddr_i (st_idx),
        .wdata_i (st_sample.raw),
        .raddr_i (rd_idx),
        .rdata_o (buf_rdata)
    );

endmodule

/* testbench/equalizer_checker.sv */
`include "eq_cfg.svh"

module equalizer_checker
    import ofdm_sample_pkg::*;
    import ofdm_carrier_pkg::*;
(
    input  logic    clock,
    input  logic    reset,
    input  sample_t in_sample_i,
    input  logic    in_stb_i,
    input  sample_t out_sample_i,
    input  logic    out_stb_i,
    input  prod_t   pilot_re_i,
    input  prod_t   pilot_im_i,
    input  logic    pilot_stb_i,
    output int      value_errors_o,
    output int      count_errors_o,
    output int      pending_o
);

    sample_t lts1 [`FFT_LEN];
    sample_t est [`FFT_LEN];
    sample_t sym [`FFT_LEN];
    sample_t exp_out [$];
    prod_t   exp_pilot_re [$];
    prod_t   exp_pilot_im [$];
    int      in_cnt = 0;
    int      pol_ptr = 0;
    logic    cur_pol;
    int      pilots_seen;
    longint  acc_re;
    longint  acc_im;
    int      value_errors = 0;
    int      count_errors = 0;
    int      pending = 0;

    assign value_errors_o = value_errors;
    assign count_errors_o = count_errors;
    assign pending_o = pending;

    function automatic sample_t mean_estimate(sample_t a, sample_t b, logic neg);
        int      re;
        int      im;
        sample_t m;
        re = (int'(a.iq.re) + int'(b.iq.re)) >>> 1;
        im = (int'(a.iq.im) + int'(b.iq.im)) >>> 1;
        if (neg) begin
            re = -re;
            im = -im;
        end
        m.iq.re = re[`IQ_W-1:0];
        m.iq.im = im[`IQ_W-1:0];
        return m;
    endfunction

    // x times conj(h), scaled, over |h|^2 cut to the divisor width
    function automatic sample_t normalize(sample_t x, sample_t h);
        longint  num_re;
        longint  num_im;
        longint  mag;
        prod_t   div_re;
        prod_t   div_im;
        longint  q_re;
        longint  q_im;
        sample_t r;
        num_re = longint'(x.iq.re) * h.iq.re + longint'(x.iq.im) * h.iq.im;
        num_im = longint'(x.iq.im) * h.iq.re - longint'(x.iq.re) * h.iq.im;
        div_re = prod_t'(num_re <<< `EQ_SCALE_SHIFT);
        div_im = prod_t'(num_im <<< `EQ_SCALE_SHIFT);
        mag = longint'(h.iq.re) * h.iq.re + longint'(h.iq.im) * h.iq.im;
        mag = mag % (longint'(1) << `DIV_DIVISOR_W);
        q_re = longint'(div_re) / mag;
        q_im = longint'(div_im) / mag;
        r.raw = {q_re[63], q_re[`IQ_W-2:0], q_im[63], q_im[`IQ_W-2:0]};
        return r;
    endfunction

    task automatic add_pilot(int k);
        logic   neg;
        longint cr;
        longint ci;
        neg = (k == 21) ? !cur_pol : cur_pol;
        cr = neg ? -longint'(sym[k].iq.re) : longint'(sym[k].iq.re);
        ci = neg ? longint'(sym[k].iq.im) : -longint'(sym[k].iq.im);
        acc_re += cr * est[k].iq.re - ci * est[k].iq.im;
        acc_im += cr * est[k].iq.im + ci * est[k].iq.re;
        pilots_seen++;
        if (pilots_seen == `NUM_PILOTS) begin
            exp_pilot_re.push_back(prod_t'(acc_re));
            exp_pilot_im.push_back(prod_t'(acc_im));
        end
    endtask

    task automatic take_sample(sample_t s);
        int k;
        k = in_cnt % `FFT_LEN;
        if (in_cnt < `FFT_LEN) begin
            lts1[k] = s;
        end else if (in_cnt < 2 * `FFT_LEN) begin
            est[k] = mean_estimate(lts1[k], s, LTS_REF[k]);
        end else begin
            sym[k] = s;
            if (k == 0) begin
                cur_pol = POLARITY_SEQ[pol_ptr];
                pol_ptr = (pol_ptr + 1) % POLARITY_LEN;
                acc_re = 0;
                acc_im = 0;
                pilots_seen = 0;
            end
            if (PILOT_MASK[k]) begin
                add_pilot(k);
            end
            if (k == `FFT_LEN - 1) begin
                for (int c = 0; c < `FFT_LEN; c++) begin
                    if (DATA_MASK[c]) begin
                        exp_out.push_back(normalize(sym[c], est[c]));
                    end
                end
            end
        end
        in_cnt++;
    endtask

    task automatic check_pilot();
        prod_t want_re;
        prod_t want_im;
        if (exp_pilot_re.size() == 0) begin
            $display("pilot sum strobe at time %0t with no pilot sum due", $time);
            count_errors++;
        end else begin
            want_re = exp_pilot_re.pop_front();
            want_im = exp_pilot_im.pop_front();
            if (pilot_re_i !== want_re || pilot_im_i !== want_im) begin
                $display("[ERROR] %0t pilot sum got %0d %0d expected %0d %0d",
                         $time, pilot_re_i, pilot_im_i, want_re, want_im);
                value_errors++;
            end
        end
    endtask

    task automatic check_output();
        sample_t want;
        if (exp_out.size() == 0) begin
            $display("carrier output strobe at time %0t with no output due", $time);
            count_errors++;
        end else begin
            want = exp_out.pop_front();
            if (out_sample_i.raw !== want.raw) begin
                $display("[ERROR] %0t carrier output got %0d %0d expected %0d %0d",
                         $time, out_sample_i.iq.re, out_sample_i.iq.im,
                         want.iq.re, want.iq.im);
                value_errors++;
            end
        end
    endtask

    // negedge keeps sampling clear of the drive and update points
    always @(negedge clock) begin
        if (reset) begin
            if (exp_out.size() != 0 || exp_pilot_re.size() != 0) begin
                $display("reset at time %0t with %0d outputs and %0d pilot sums still due",
                         $time, exp_out.size(), exp_pilot_re.size());
                count_errors++;
            end
            exp_out.delete();
            exp_pilot_re.delete();
            exp_pilot_im.delete();
            in_cnt = 0;
            pol_ptr = 0;
        end else begin
            if (in_stb_i) begin
                take_sample(in_sample_i);
            end
            if (pilot_stb_i) begin
                check_pilot();
            end
            if (out_stb_i) begin
                check_output();
            end
        end
        pending = exp_out.size() + exp_pilot_re.size();
    end

endmodule

/* testbench/equalizer_properties.sv */
`include "eq_cfg.svh"

module equalizer_properties (
    input logic clock,
    input logic reset,
    input logic sample_stb_i,
    input logic sample_stb_o,
    input logic pilot_sum_stb_o
);

    int                             assert_errors = 0;
    logic [`FFT_ADDR_W+1:0]         lts_cnt;
    logic [`FFT_ADDR_W-1:0]         in_cnt;
    logic [`FFT_ADDR_W-1:0]         out_cnt;
    logic                           busy;

    // busy spans the 64th input of a data symbol up to its 48th output
    always_ff @(posedge clock) begin
        if (reset) begin
            lts_cnt <= '0;
            in_cnt <= '0;
            out_cnt <= '0;
            busy <= 1'b0;
        end else begin
            if (sample_stb_i) begin
                if (lts_cnt < 2 * `FFT_LEN) begin
                    lts_cnt <= lts_cnt + 1'b1;
                end else begin
                    in_cnt <= in_cnt + 1'b1;
                    if (in_cnt == `FFT_LEN - 1) begin
                        busy <= 1'b1;
                    end
                end
            end
            if (sample_stb_o) begin
                if (out_cnt == `NUM_DATA_CARRIERS - 1) begin
                    out_cnt <= '0;
                    busy <= 1'b0;
                end else begin
                    out_cnt <= out_cnt + 1'b1;
                end
            end
        end
    end

    strobes_low_after_reset: assert property (@(posedge clock)
        reset |=> !sample_stb_o && !pilot_sum_stb_o)
        else begin
            $error("output strobe high in the cycle after reset");
            assert_errors++;
        end

    pilot_strobe_single: assert property (@(posedge clock) disable iff (reset)
        pilot_sum_stb_o |=> !pilot_sum_stb_o)
        else begin
            $error("pilot sum strobe held for more than one cycle");
            assert_errors++;
        end

    no_input_during_readout: assert property (@(posedge clock) disable iff (reset)
        busy |-> !sample_stb_i)
        else begin
            $error("sample strobe arrived before the 48th output of the symbol");
            assert_errors++;
        end

endmodule

bind equalizer_top equalizer_properties u_props (
    .clock           (clock),
    .reset           (reset),
    .sample_stb_i    (sample_stb_i),
    .sample_stb_o    (sample_stb_o),
    .pilot_sum_stb_o (pilot_sum_stb_o)
);

/* testbench/equalizer_tb.sv */
`include "eq_cfg.svh"

module equalizer_tb
    import ofdm_sample_pkg::*;
();

    localparam int LTS_MIN = 200;
    localparam int OUT_TIMEOUT = 6000;
    localparam int NUM_ROWS = 13;

    typedef enum int {KIND_LTS1, KIND_LTS2, KIND_DATA, KIND_RESET} kind_t;

    typedef struct {
        kind_t kind;
        int    gap;
        int    range;
    } row_t;

    // kind, idle cycles after each strobe, component bound
    // an estimate within 500 keeps the scaled numerator inside 32 bits
    // six data symbols reach polarity bits 4 and 5, the first ones set
    row_t rows [NUM_ROWS] = '{
        '{KIND_LTS1, 0, 500},
        '{KIND_LTS2, 0, 500},
        '{KIND_DATA, 0, 1000},
        '{KIND_DATA, 1, 1000},
        '{KIND_DATA, 3, 1000},
        '{KIND_DATA, 0, 1000},
        '{KIND_DATA, 2, 1000},
        '{KIND_DATA, 0, 1000},
        '{KIND_RESET, 0, 0},
        '{KIND_LTS1, 2, 400},
        '{KIND_LTS2, 1, 400},
        '{KIND_DATA, 0, 1000},
        '{KIND_DATA, 2, 1000}
    };

    logic    clock;
    logic    reset;
    sample_t sample_i;
    logic    sample_stb_i;
    sample_t sample_o;
    logic    sample_stb_o;
    prod_t   pilot_sum_re_o;
    prod_t   pilot_sum_im_o;
    logic    pilot_sum_stb_o;
    logic    lts_neg_re [`FFT_LEN];
    logic    lts_neg_im [`FFT_LEN];
    int      out_seen;
    logic    timed_out;
    int      value_errors;
    int      count_errors;
    int      pending;

    initial clock = 1'b0;
    always #2 clock = ~clock;

    always @(posedge clock) begin
        if (reset) begin
            out_seen <= 0;
        end else if (sample_stb_o) begin
            out_seen <= out_seen + 1;
        end
    end

    equalizer_top uut (
        .clock           (clock),
        .reset           (reset),
        .sample_i        (sample_i),
        .sample_stb_i    (sample_stb_i),
        .sample_o        (sample_o),
        .sample_stb_o    (sample_stb_o),
        .pilot_sum_re_o  (pilot_sum_re_o),
        .pilot_sum_im_o  (pilot_sum_im_o),
        .pilot_sum_stb_o (pilot_sum_stb_o)
    );

    equalizer_checker u_checker (
        .clock          (clock),
        .reset          (reset),
        .in_sample_i    (sample_i),
        .in_stb_i       (sample_stb_i),
        .out_sample_i   (sample_o),
        .out_stb_i      (sample_stb_o),
        .pilot_re_i     (pilot_sum_re_o),
        .pilot_im_i     (pilot_sum_im_o),
        .pilot_stb_i    (pilot_sum_stb_o),
        .value_errors_o (value_errors),
        .count_errors_o (count_errors),
        .pending_o      (pending)
    );

    function automatic int pick_data(int range);
        return int'($urandom % (2 * range + 1)) - range;
    endfunction

    function automatic int pick_lts(int range, logic neg);
        int mag;
        mag = LTS_MIN + int'($urandom % (range - LTS_MIN + 1));
        return neg ? -mag : mag;
    endfunction

    task automatic apply_reset();
        reset = 1'b1;
        repeat (2) begin
            @(posedge clock);
            #1;
        end
        reset = 1'b0;
    endtask

    task automatic send_symbol(kind_t kind, int gap, int range);
        sample_t s;
        int      re;
        int      im;
        for (int k = 0; k < `FFT_LEN; k++) begin
            if (kind == KIND_DATA) begin
                re = pick_data(range);
                im = pick_data(range);
            end else begin
                // second LTS keeps the signs of the first so the mean stays large
                if (kind == KIND_LTS1) begin
                    lts_neg_re[k] = ($urandom % 2) != 0;
                    lts_neg_im[k] = ($urandom % 2) != 0;
                end
                re = pick_lts(range, lts_neg_re[k]);
                im = pick_lts(range, lts_neg_im[k]);
            end
            s.iq.re = re[`IQ_W-1:0];
            s.iq.im = im[`IQ_W-1:0];
            sample_i = s;
            sample_stb_i = 1'b1;
            @(posedge clock);
            #1;
            sample_stb_i = 1'b0;
            repeat (gap) begin
                @(posedge clock);
                #1;
            end
        end
    endtask

    task automatic wait_outputs(int target);
        int cycles;
        cycles = 0;
        while (out_seen < target && cycles < OUT_TIMEOUT) begin
            @(posedge clock);
            #1;
            cycles++;
        end
        if (out_seen < target) begin
            $display("timeout: only %0d of %0d carrier outputs arrived for a data symbol",
                     out_seen, target);
            timed_out = 1'b1;
        end
    endtask

    initial begin
        int total;
        int target;
        void'($urandom(32'hd69e9181));
        reset = 1'b1;
        sample_i = '0;
        sample_stb_i = 1'b0;
        timed_out = 1'b0;
        apply_reset();

        for (int r = 0; r < NUM_ROWS; r++) begin
            case (rows[r].kind)
                KIND_RESET: begin
                    apply_reset();
                end
                KIND_DATA: begin
                    target = out_seen + `NUM_DATA_CARRIERS;
                    send_symbol(rows[r].kind, rows[r].gap, rows[r].range);
                    wait_outputs(target);
                end
                default: begin
                    send_symbol(rows[r].kind, rows[r].gap, rows[r].range);
                end
            endcase
            if (timed_out) begin
                break;
            end
        end

        repeat (20) begin
            @(posedge clock);
            #1;
        end
        total = value_errors + count_errors + uut.u_props.assert_errors + pending;
        $display("errors: value %0d, count %0d, assertion %0d, pending %0d",
                 value_errors, count_errors, uut.u_props.assert_errors, pending);
        if (!timed_out && total == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
